// File: source/host_bridge_pkg.sv
package host_bridge_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Full pointer width for a 2^19 byte window
    localparam int ADDR_W = 19;

    // Work memory only decodes the low bits
    localparam int RAM_AW = 11;

    // Auto-increment step
    localparam int INCR_W = 4;

    // Upper pointer bits held in the control byte
    localparam int BANK_W = ADDR_W - 16;

    // Host register index width
    localparam int IDX_W = 3;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    localparam logic [IDX_W-1:0] REG_CTRL = 3'd0;
    localparam logic [IDX_W-1:0] REG_MID  = 3'd1;
    localparam logic [IDX_W-1:0] REG_LOW  = 3'd2;
    localparam logic [IDX_W-1:0] REG_DATA = 3'd3;

    // Control byte as seen field by field
    typedef struct packed {
        logic [INCR_W-1:0] incr;
        logic              spare;
        logic [BANK_W-1:0] bank;
    } host_ctrl_fields_t;

    // Same byte either raw on the bus or decoded
    typedef union packed {
        logic [7:0]        raw;
        host_ctrl_fields_t f;
    } host_ctrl_u;

    // One-cycle request from the bus slave
    typedef struct packed {
        logic             valid;
        logic             write;
        logic [IDX_W-1:0] idx;
        logic [7:0]       wdata;
    } host_req_t;

    // Engine state for register readback
    typedef struct packed {
        host_ctrl_u ctrl;
        logic [7:0] mid;
        logic [7:0] low;
        logic [7:0] fetched;
    } reg_view_t;

    // Access towards the work memory
    typedef struct packed {
        logic              strobe;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } mem_req_t;

endpackage

// File: source/work_ram.sv
`timescale 1ns/100ps

module work_ram (
    input  logic                      extbus_phy2,

    // Access from the pointer engine
    input  host_bridge_pkg::mem_req_t mem,
    output logic [7:0]                rdata
);

    import host_bridge_pkg::*;

    logic [7:0]        ram_q [2 ** RAM_AW];
    logic [RAM_AW-1:0] ram_addr;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Upper pointer bits alias onto the same bytes
    assign ram_addr = mem.addr[RAM_AW-1:0];

    always_ff @(posedge extbus_phy2) begin
        if (mem.strobe) begin
            if (mem.write) begin
                ram_q[ram_addr] <= mem.wdata;
            end else begin
                // Valid one cycle after the strobe
                rdata <= ram_q[ram_addr];
            end
        end
    end

    // Engine always presents a known address with the strobe
    a_addr_known: assert property (
        @(posedge extbus_phy2)
        mem.strobe |-> !$isunknown(mem.addr)
    );

endmodule

// File: source/host_bus_slave.sv
`timescale 1ns/100ps

module host_bus_slave (
    input  logic                            extbus_phy2,
    input  logic                            bm_busy_done,

    // Host side
    input  logic                            cs_n,
    input  logic                            rw_n,
    input  logic [host_bridge_pkg::IDX_W-1:0] a,
    input  logic [7:0]                      d_in,
    output logic [7:0]                      d_out,
    output logic                            d_oe,
    output logic                            rdy,

    // Engine side
    output host_bridge_pkg::host_req_t      req,
    input  host_bridge_pkg::reg_view_t      view,
    input  logic                            fetch_busy
);

    import host_bridge_pkg::*;

    logic             sel_q;
    logic             valid_q;
    logic             write_q;
    logic [IDX_W-1:0] idx_q;
    logic [7:0]       wdata_q;
    logic             sel_edge;
    logic             data_rd_req;
    logic [7:0]       rd_byte;

    ////////////////////////////////////////
    // Selection edge and request capture
    ////////////////////////////////////////

    // First edge that sees chip select low
    assign sel_edge = ~cs_n & ~sel_q;

    always_ff @(posedge extbus_phy2 or posedge bm_busy_done) begin
        if (bm_busy_done) begin
            sel_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            sel_q   <= ~cs_n;
            // Single pulse per selection
            valid_q <= sel_edge;
        end
    end

    // Host keeps a, rw_n and data stable while selected
    always_ff @(posedge extbus_phy2) begin
        if (sel_edge) begin
            write_q <= ~rw_n;
            idx_q   <= a;
            wdata_q <= d_in;
        end
    end

    assign req = '{valid: valid_q, write: write_q, idx: idx_q, wdata: wdata_q};

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////

    // Follows the address directly and upper indices read zero
    always_comb begin
        case (a)
            REG_CTRL: rd_byte = view.ctrl.raw;
            REG_MID:  rd_byte = view.mid;
            REG_LOW:  rd_byte = view.low;
            REG_DATA: rd_byte = view.fetched;
            default:  rd_byte = 8'h00;
        endcase
    end

    assign d_out = rd_byte;
    assign d_oe  = ~cs_n & rw_n;

    ////////////////////////////////////////
    // Ready
    ////////////////////////////////////////

    // Data-port read about to start a fetch
    assign data_rd_req = req.valid & ~req.write & (req.idx == REG_DATA);

    // Hold the host off until the fetched byte lands
    assign rdy = ~(~cs_n & (data_rd_req | fetch_busy));

    // Requests are single cycle
    a_req_single: assert property (
        @(posedge extbus_phy2) disable iff (bm_busy_done)
        req.valid |=> !req.valid
    );

    // A write request never sees the data bus driven
    a_no_oe_on_write: assert property (
        @(posedge extbus_phy2) disable iff (bm_busy_done)
        (req.valid && req.write) |-> !d_oe
    );

endmodule

// File: source/pointer_engine.sv
`timescale 1ns/100ps

module pointer_engine (
    input  logic                       extbus_phy2,
    input  logic                       bm_busy_done,

    input  host_bridge_pkg::host_req_t req,
    output host_bridge_pkg::reg_view_t view,
    output logic                       fetch_busy,

    // Work memory port
    output host_bridge_pkg::mem_req_t  mem,
    input  logic [7:0]                 rdata
);

    import host_bridge_pkg::*;

    // Incoming byte decoded as a control word
    host_ctrl_u        wr_ctrl;
    host_ctrl_u        view_ctrl;

    logic [INCR_W-1:0] incr_q;
    logic [ADDR_W-1:0] ptr_q;
    logic [7:0]        fetched_q;
    logic              busy_q;
    logic              rd_pend_q;
    logic              strobe_q;
    logic              write_q;
    logic [ADDR_W-1:0] acc_addr_q;
    logic [7:0]        acc_wdata_q;
    logic              data_req;
    logic              data_rd;

    assign wr_ctrl.raw = req.wdata;

    assign data_req = req.valid & (req.idx == REG_DATA);
    assign data_rd  = data_req & ~req.write;

    ////////////////////////////////////////
    // Registers, pointer and fetch tracking
    ////////////////////////////////////////

    always_ff @(posedge extbus_phy2 or posedge bm_busy_done) begin
        if (bm_busy_done) begin
            incr_q    <= '0;
            ptr_q     <= '0;
            fetched_q <= '0;
            busy_q    <= 1'b0;
            rd_pend_q <= 1'b0;
            strobe_q  <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            // Memory access goes out one edge after the request
            strobe_q  <= data_req;
            write_q   <= data_req & req.write;

            // RAM registers its output on the next edge
            rd_pend_q <= strobe_q & ~write_q;

            // Busy from issue until the byte is captured
            busy_q    <= data_rd | (busy_q & ~rd_pend_q);

            if (rd_pend_q) begin
                fetched_q <= rdata;
            end

            if (req.valid && req.write) begin
                case (req.idx)
                    REG_CTRL: begin
                        incr_q               <= wr_ctrl.f.incr;
                        ptr_q[ADDR_W-1:16]   <= wr_ctrl.f.bank;
                    end
                    REG_MID: ptr_q[15:8] <= req.wdata;
                    REG_LOW: ptr_q[7:0]  <= req.wdata;
                    default: ;
                endcase
            end

            // Step wraps modulo 2^19
            if (data_req) begin
                ptr_q <= ptr_q + ADDR_W'(incr_q);
            end
        end
    end

    // Access address and write byte latched with the strobe
    always_ff @(posedge extbus_phy2) begin
        if (data_req) begin
            acc_addr_q  <= ptr_q;
            acc_wdata_q <= req.wdata;
        end
    end

    assign mem = '{strobe: strobe_q, write: write_q, addr: acc_addr_q, wdata: acc_wdata_q};

    ////////////////////////////////////////
    // Readback view
    ////////////////////////////////////////

    always_comb begin
        view_ctrl.f.incr  = incr_q;
        view_ctrl.f.spare = 1'b0;
        view_ctrl.f.bank  = ptr_q[ADDR_W-1:16];
    end

    assign view = '{ctrl: view_ctrl, mid: ptr_q[15:8], low: ptr_q[7:0], fetched: fetched_q};

    assign fetch_busy = busy_q;

    // Host must wait on rdy before the next access
    a_no_req_while_busy: assert property (
        @(posedge extbus_phy2) disable iff (bm_busy_done)
        req.valid |-> !fetch_busy
    );

endmodule

// File: source/host_bridge_top.sv
`timescale 1ns/100ps

module host_bridge_top (
    input  logic                              extbus_phy2,
    input  logic                              bm_busy_done,

    // 6502-style host bus
    input  logic                              cs_n,
    input  logic                              rw_n,
    input  logic [host_bridge_pkg::IDX_W-1:0] a,
    input  logic [7:0]                        d_in,
    output logic [7:0]                        d_out,
    output logic                              d_oe,
    output logic                              rdy
);

    import host_bridge_pkg::*;

    host_req_t  req;
    reg_view_t  view;
    mem_req_t   mem;
    logic       fetch_busy;
    logic [7:0] rdata;

    ////////////////////////////////////////
    // Bus slave
    ////////////////////////////////////////

    host_bus_slave i_slave (
        .extbus_phy2  (extbus_phy2),
        .bm_busy_done (bm_busy_done),
        .cs_n         (cs_n),
        .rw_n         (rw_n),
        .a            (a),
        .d_in         (d_in),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .rdy          (rdy),
        .req          (req),
        .view         (view),
        .fetch_busy   (fetch_busy)
    );

    // Pointer and fetch state
    pointer_engine i_engine (
        .extbus_phy2  (extbus_phy2),
        .bm_busy_done (bm_busy_done),
        .req          (req),
        .view         (view),
        .fetch_busy   (fetch_busy),
        .mem          (mem),
        .rdata        (rdata)
    );

    work_ram i_ram (
        .extbus_phy2 (extbus_phy2),
        .mem         (mem),
        .rdata       (rdata)
    );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic extbus_phy2,
    output logic bm_busy_done
);

    // 20 ns period
    initial begin
        extbus_phy2 = 1'b0;
        forever #10 extbus_phy2 = ~extbus_phy2;
    end

    // Reset held for 16 rising edges, released just after the last one
    initial begin
        bm_busy_done = 1'b1;
        repeat (16) @(posedge extbus_phy2);
        #1;
        bm_busy_done = 1'b0;
    end

endmodule

// File: bench/bridge_tb.sv
`timescale 1ns/100ps

module bridge_tb;

    import host_bridge_pkg::*;

    // 600 host cycles at 10 clocks each plus reset margin
    localparam int TIMEOUT_CYCLES = 600 * 10 + 100;
    localparam int RANDOM_OPS     = 400;

    logic             extbus_phy2;
    logic             bm_busy_done;
    logic             cs_n;
    logic             rw_n;
    logic [IDX_W-1:0] a;
    logic [7:0]       d_in;
    logic [7:0]       d_out;
    logic             d_oe;
    logic             rdy;
    int               cycle_cnt;

    // Reference model
    logic [INCR_W-1:0] m_incr;
    logic [ADDR_W-1:0] m_ptr;
    logic [7:0]        m_fetched;
    bit                m_fetch_known;
    logic [7:0]        m_mem [2**RAM_AW];
    bit                m_written [2**RAM_AW];

    clock_gen i_clk (.extbus_phy2(extbus_phy2), .bm_busy_done(bm_busy_done));

    host_bridge_top i_dut (
        .extbus_phy2  (extbus_phy2),
        .bm_busy_done (bm_busy_done),
        .cs_n         (cs_n),
        .rw_n         (rw_n),
        .a            (a),
        .d_in         (d_in),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .rdy          (rdy)
    );

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ctrl(input string name, input host_ctrl_u got, input host_ctrl_u exp);
        if (got.raw !== exp.raw) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic host_ctrl_u expected_ctrl();
        host_ctrl_u c;
        c.f.incr  = m_incr;
        c.f.spare = 1'b0;
        c.f.bank  = m_ptr[ADDR_W-1:16];
        return c;
    endfunction

    ////////////////////////////////////////
    // Host bus cycles
    ////////////////////////////////////////

    task automatic host_cycle(input logic write, input logic [IDX_W-1:0] idx,
                              input logic [7:0] wdata, output logic [7:0] rd);
        logic data_read;
        int   i;
        data_read = !write && (idx == REG_DATA);
        cs_n = 1'b0;
        rw_n = !write;
        a    = idx;
        d_in = wdata;
        // Request cycle right after the selection edge
        @(posedge extbus_phy2);
        #1;
        check_bit("rdy", rdy, !data_read);
        check_bit("d_oe", d_oe, !write);
        @(posedge extbus_phy2);
        #1;
        rd = d_out;
        if (data_read) begin
            // Fetch in flight until three cycles after req
            for (i = 1; i < 3; i++) begin
                check_bit("rdy", rdy, 1'b0);
                @(posedge extbus_phy2);
                #1;
            end
        end
        check_bit("rdy", rdy, 1'b1);
        cs_n = 1'b1;
        rw_n = 1'b1;
        @(posedge extbus_phy2);
        #1;
        check_bit("d_oe", d_oe, 1'b0);
    endtask

    task automatic reg_write(input logic [IDX_W-1:0] idx, input logic [7:0] data);
        logic [7:0] unused_rd;
        host_ctrl_u c;
        host_cycle(1'b1, idx, data, unused_rd);
        c.raw = data;
        case (idx)
            REG_CTRL: begin
                m_incr = c.f.incr;
                m_ptr[ADDR_W-1:16] = c.f.bank;
            end
            REG_MID: m_ptr[15:8] = data;
            REG_LOW: m_ptr[7:0] = data;
            REG_DATA: begin
                m_mem[m_ptr[RAM_AW-1:0]] = data;
                m_written[m_ptr[RAM_AW-1:0]] = 1'b1;
                m_ptr = m_ptr + ADDR_W'(m_incr);
            end
            default: ;
        endcase
    endtask

    task automatic reg_read(input logic [IDX_W-1:0] idx);
        logic [7:0] got;
        host_ctrl_u got_ctrl;
        host_cycle(1'b0, idx, 8'h00, got);
        got_ctrl.raw = got;
        case (idx)
            REG_CTRL: check_ctrl("ctrl", got_ctrl, expected_ctrl());
            REG_MID:  check_byte("mid", got, m_ptr[15:8]);
            REG_LOW:  check_byte("low", got, m_ptr[7:0]);
            REG_DATA: begin
                // Returns the previous fetch and fetches at the pointer
                if (m_fetch_known) begin
                    check_byte("data", got, m_fetched);
                end
                m_fetched     = m_mem[m_ptr[RAM_AW-1:0]];
                m_fetch_known = m_written[m_ptr[RAM_AW-1:0]];
                m_ptr         = m_ptr + ADDR_W'(m_incr);
            end
            default:  check_byte("unused", got, 8'h00);
        endcase
    endtask

    task automatic set_pointer(input logic [INCR_W-1:0] incr, input logic [ADDR_W-1:0] p);
        host_ctrl_u c;
        c.f.incr  = incr;
        c.f.spare = 1'b0;
        c.f.bank  = p[ADDR_W-1:16];
        reg_write(REG_CTRL, c.raw);
        reg_write(REG_MID, p[15:8]);
        reg_write(REG_LOW, p[7:0]);
    endtask

    task automatic read_pointer();
        reg_read(REG_CTRL);
        reg_read(REG_MID);
        reg_read(REG_LOW);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_values();
        int i;
        check_bit("rdy", rdy, 1'b1);
        for (i = 0; i < 8; i++) begin
            reg_read(IDX_W'(i));
        end
    endtask

    task automatic test_register_rw();
        int i;
        // Spare bit of the control byte is written at random
        for (i = 0; i < 8; i++) begin
            reg_write(REG_CTRL, 8'($urandom()));
            reg_write(REG_MID, 8'($urandom()));
            reg_write(REG_LOW, 8'($urandom()));
            read_pointer();
        end
    endtask

    task automatic test_burst();
        logic [INCR_W-1:0] incr;
        logic [ADDR_W-1:0] base;
        int                i;
        incr = INCR_W'($urandom_range(1, 15));
        base = ADDR_W'($urandom());
        set_pointer(incr, base);
        for (i = 0; i < 12; i++) begin
            reg_write(REG_DATA, 8'($urandom()));
        end
        read_pointer();
        set_pointer(incr, base);
        for (i = 0; i < 13; i++) begin
            reg_read(REG_DATA);
        end
        read_pointer();
    endtask

    task automatic test_wrap_alias();
        logic [ADDR_W-1:0] top;
        logic [ADDR_W-1:0] alias_ptr;
        int                i;
        top = ADDR_W'(2**ADDR_W - 7);
        set_pointer(4'd5, top);
        // Third write lands past the top of the window
        for (i = 0; i < 4; i++) begin
            reg_write(REG_DATA, 8'($urandom()));
        end
        read_pointer();
        // Same low bits k times 2048 bytes away
        alias_ptr = top + ADDR_W'($urandom_range(1, 255) << RAM_AW);
        set_pointer(4'd5, alias_ptr);
        for (i = 0; i < 4; i++) begin
            reg_read(REG_DATA);
        end
        read_pointer();
    endtask

    task automatic test_random_mix();
        int         n;
        int         op;
        logic [7:0] data;
        for (n = 0; n < RANDOM_OPS; n++) begin
            op   = $urandom_range(0, 9);
            data = 8'($urandom());
            case (op)
                0: reg_write(REG_CTRL, data);
                1: reg_write(REG_MID, data);
                2: reg_write(REG_LOW, data);
                3, 4, 5: reg_write(REG_DATA, data);
                6, 7: begin
                    // Fetch only from bytes already stored
                    if (m_written[m_ptr[RAM_AW-1:0]]) begin
                        reg_read(REG_DATA);
                    end else begin
                        reg_write(REG_DATA, data);
                    end
                end
                default: reg_read(IDX_W'($urandom_range(0, 7)));
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge extbus_phy2);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end

    initial begin
        cs_n          = 1'b1;
        rw_n          = 1'b1;
        a             = '0;
        d_in          = '0;
        m_incr        = '0;
        m_ptr         = '0;
        m_fetched     = '0;
        m_fetch_known = 1'b1;
        m_mem         = '{default: 8'h00};
        m_written     = '{default: 1'b0};
        void'($urandom(23));
        @(negedge bm_busy_done);
        @(posedge extbus_phy2);
        #1;
        test_reset_values();
        test_register_rw();
        test_burst();
        test_wrap_alias();
        test_random_mix();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: list.f
source/host_bridge_pkg.sv
source/work_ram.sv
source/host_bus_slave.sv
source/pointer_engine.sv
source/host_bridge_top.sv
bench/clock_gen.sv
bench/bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the host bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module bridge_tb \
    --Mdir obj_dir \
    -f list.f

# Exit status of the simulation is ignored, the log decides
./obj_dir/Vbridge_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
